// File: src/ft_bridge_pkg.sv
`default_nettype none

package ft_bridge_pkg;

    // ==============================
    // Bus and word widths
    // ==============================
    // FT601 payload and byte-enable lanes
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;
    // Channel code rides in the top two byte-enable bits
    localparam int CH_W   = 2;
    // Buffer word is {channel, byte-valid, data}
    localparam int WORD_W = 36;

    // Field offsets inside a buffer word
    localparam int DATA_LSB = 0;
    localparam int BV_LSB   = 32;
    localparam int CH_LSB   = 34;

    // Both low byte lanes valid on every word we send
    localparam logic [BE_W-CH_W-1:0] BV_ALL = 2'b11;

    // Channel codes
    // EP0 is control, EP1 bulk OUT, EP2 and EP3 bulk IN
    localparam logic [CH_W-1:0] CH_EP0 = 2'd0;
    localparam logic [CH_W-1:0] CH_EP1 = 2'd1;
    localparam logic [CH_W-1:0] CH_EP2 = 2'd2;
    localparam logic [CH_W-1:0] CH_EP3 = 2'd3;

    // ==============================
    // Buffers and counters
    // ==============================
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int CNT_W      = 32;

    // Bus FSM state codes
    localparam int STATE_W = 3;
    localparam logic [STATE_W-1:0] ST_IDLE     = 3'd0;
    localparam logic [STATE_W-1:0] ST_RX_OE    = 3'd1;
    localparam logic [STATE_W-1:0] ST_RX_READ  = 3'd2;
    localparam logic [STATE_W-1:0] ST_RX_WAIT  = 3'd3;
    localparam logic [STATE_W-1:0] ST_TX_SETUP = 3'd4;
    localparam logic [STATE_W-1:0] ST_TX_WRITE = 3'd5;
    localparam logic [STATE_W-1:0] ST_TX_WAIT  = 3'd6;

endpackage

`default_nettype wire

// File: src/fifo_if.sv
`default_nettype none

interface fifo_if;
    import ft_bridge_pkg::*;

    // Push side
    logic              push;
    logic [WORD_W-1:0] push_word;
    logic              full;

    // Pop side, head is visible without a read delay
    logic              pop;
    logic [WORD_W-1:0] head_word;
    logic              empty;

    // Block writing into the buffer
    modport producer (output push, output push_word, input full);

    // Block draining the buffer
    modport consumer (output pop, input head_word, input empty);

    // The buffer itself
    modport store (
        input  push, input  push_word, output full,
        input  pop,  output head_word, output empty
    );

endinterface

`default_nettype wire

// File: src/word_fifo.sv
`default_nettype none

module word_fifo (
    input logic   ft_clk,
    input logic   sys_rst_n,
    fifo_if.store fifo
);
    import ft_bridge_pkg::*;

    // ==============================
    // Storage and pointers
    // ==============================
    logic [WORD_W-1:0] mem [FIFO_DEPTH];

    // One extra bit tells a wrapped full from empty
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;

    logic do_push;
    logic do_pop;

    // Guard against a push on full or a pop on empty
    assign do_push = fifo.push && !fifo.full;
    assign do_pop  = fifo.pop && !fifo.empty;

    // Pointer update
    always_ff @(posedge ft_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + (FIFO_AW+1)'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + (FIFO_AW+1)'(1);
            end
        end
    end

    // Data array
    always_ff @(posedge ft_clk) begin
        if (do_push) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= fifo.push_word;
        end
    end

    // ==============================
    // Flags and show-ahead head
    // ==============================
    // Same address with opposite wrap bits means full
    assign fifo.full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                        (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
    assign fifo.empty = (wr_ptr == rd_ptr);

    // Oldest word straight from the array
    assign fifo.head_word = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

`default_nettype wire

// File: src/ft_bus_fsm.sv
`default_nettype none

module ft_bus_fsm (
    input  logic                             ft_clk,
    input  logic                             sys_rst_n,
    // FT601 flags, low means ready
    input  logic                             rxf_n,
    input  logic                             txe_n,
    input  logic [ft_bridge_pkg::DATA_W-1:0] data_in,
    input  logic [ft_bridge_pkg::BE_W-1:0]   be_in,
    // FT601 strobes, all active low
    output logic                             rd_n,
    output logic                             wr_n,
    output logic                             oe_n,
    output logic [ft_bridge_pkg::DATA_W-1:0] data_out,
    output logic [ft_bridge_pkg::BE_W-1:0]   be_out,
    output logic                             data_oe,
    // Buffers
    fifo_if.producer                         rx_buf,
    fifo_if.consumer                         tx_buf
);
    import ft_bridge_pkg::*;

    logic [STATE_W-1:0] state;
    logic [STATE_W-1:0] state_next;

    // A receive word can move when the chip has data and we have room
    logic rx_ok;
    // A transmit word can move when the chip has room and we have data
    logic tx_ok;

    assign rx_ok = !rxf_n && !rx_buf.full;
    assign tx_ok = !txe_n && !tx_buf.empty;

    // ==============================
    // Bus sequence
    // ==============================
    always_ff @(posedge ft_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // Receive wins when both sides are ready
                if (rx_ok) begin
                    state_next = ST_RX_OE;
                end else if (tx_ok) begin
                    state_next = ST_TX_SETUP;
                end
            end
            // Turnaround, chip starts driving the bus
            ST_RX_OE:    state_next = ST_RX_READ;
            ST_RX_READ: begin
                // Burst ends on empty chip or full buffer
                if (!rx_ok) begin
                    state_next = ST_RX_WAIT;
                end
            end
            // Turnaround, chip releases the bus
            ST_RX_WAIT:  state_next = ST_IDLE;
            // First word is put on the bus here
            ST_TX_SETUP: state_next = ST_TX_WRITE;
            ST_TX_WRITE: begin
                if (!tx_ok) begin
                    state_next = ST_TX_WAIT;
                end
            end
            ST_TX_WAIT:  state_next = ST_IDLE;
            default:     state_next = ST_IDLE;
        endcase
    end

    // ==============================
    // Strobes
    // ==============================
    // Chip drives data through RX_OE and RX_READ
    assign oe_n = !((state == ST_RX_OE) || (state == ST_RX_READ));

    // Strobes follow the live flags so each low edge moves one word
    assign rd_n = !((state == ST_RX_READ) && rx_ok);
    assign wr_n = !((state == ST_TX_WRITE) && tx_ok);

    // We own the bus from setup until the wait state ends
    assign data_oe = (state == ST_TX_SETUP) || (state == ST_TX_WRITE) ||
                     (state == ST_TX_WAIT);

    // ==============================
    // Data capture and drive
    // ==============================
    // Push on the same edge as the bus read
    assign rx_buf.push = !rd_n;

    // Pack channel, byte-valid bits and data
    always_comb begin
        rx_buf.push_word = '0;
        rx_buf.push_word[DATA_LSB +: DATA_W]    = data_in;
        rx_buf.push_word[BV_LSB +: BE_W-CH_W]   = be_in[BE_W-CH_W-1:0];
        rx_buf.push_word[CH_LSB +: CH_W]        = be_in[BE_W-1 -: CH_W];
    end

    // Head advances on every bus write
    assign tx_buf.pop = !wr_n;

    // Unpack the head word onto the bus lines
    assign data_out = tx_buf.head_word[DATA_LSB +: DATA_W];
    assign be_out   = {tx_buf.head_word[CH_LSB +: CH_W],
                       tx_buf.head_word[BV_LSB +: BE_W-CH_W]};

endmodule

`default_nettype wire

// File: src/rx_endpoint_demux.sv
`default_nettype none

module rx_endpoint_demux (
    input  logic                             ft_clk,
    input  logic                             sys_rst_n,
    input  logic                             ep0_rx_ready,
    input  logic                             ep1_rx_ready,
    output logic [ft_bridge_pkg::DATA_W-1:0] ep0_rx_data,
    output logic                             ep0_rx_valid,
    output logic [ft_bridge_pkg::DATA_W-1:0] ep1_rx_data,
    output logic                             ep1_rx_valid,
    output logic [ft_bridge_pkg::CNT_W-1:0]  rx_count,
    fifo_if.consumer                         rx_buf
);
    import ft_bridge_pkg::*;

    logic [CH_W-1:0] head_ch;
    logic            delivered;
    logic            discard;

    // Channel field of the oldest word
    assign head_ch = rx_buf.head_word[CH_LSB +: CH_W];

    // Only the matching OUT endpoint sees the word
    assign ep0_rx_valid = !rx_buf.empty && (head_ch == CH_EP0);
    assign ep1_rx_valid = !rx_buf.empty && (head_ch == CH_EP1);
    assign ep0_rx_data  = rx_buf.head_word[DATA_LSB +: DATA_W];
    assign ep1_rx_data  = rx_buf.head_word[DATA_LSB +: DATA_W];

    assign delivered = (ep0_rx_valid && ep0_rx_ready) || (ep1_rx_valid && ep1_rx_ready);

    // IN-only channels have no receiver, drop those words at once
    assign discard = !rx_buf.empty && ((head_ch == CH_EP2) || (head_ch == CH_EP3));

    assign rx_buf.pop = delivered || discard;

    // Delivered word count, drops excluded
    always_ff @(posedge ft_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rx_count <= '0;
        end else if (delivered) begin
            rx_count <= rx_count + CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: src/tx_endpoint_arbiter.sv
`default_nettype none

module tx_endpoint_arbiter (
    input  logic                             ft_clk,
    input  logic                             sys_rst_n,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep0_tx_data,
    input  logic                             ep0_tx_valid,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep2_tx_data,
    input  logic                             ep2_tx_valid,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep3_tx_data,
    input  logic                             ep3_tx_valid,
    output logic                             ep0_tx_ready,
    output logic                             ep2_tx_ready,
    output logic                             ep3_tx_ready,
    output logic [ft_bridge_pkg::CNT_W-1:0]  tx_count,
    fifo_if.producer                         tx_buf
);
    import ft_bridge_pkg::*;

    logic [CH_W-1:0]   win_ch;
    logic [DATA_W-1:0] win_data;

    // ==============================
    // Fixed priority EP0, EP2, EP3
    // ==============================
    // Ready goes to the top valid source, none while full
    assign ep0_tx_ready = !tx_buf.full && ep0_tx_valid;
    assign ep2_tx_ready = !tx_buf.full && ep2_tx_valid && !ep0_tx_valid;
    assign ep3_tx_ready = !tx_buf.full && ep3_tx_valid && !ep0_tx_valid && !ep2_tx_valid;

    // Winner's channel and payload
    always_comb begin
        if (ep0_tx_valid) begin
            win_ch   = CH_EP0;
            win_data = ep0_tx_data;
        end else if (ep2_tx_valid) begin
            win_ch   = CH_EP2;
            win_data = ep2_tx_data;
        end else begin
            win_ch   = CH_EP3;
            win_data = ep3_tx_data;
        end
    end

    // Push on the handshake edge
    assign tx_buf.push = ep0_tx_ready || ep2_tx_ready || ep3_tx_ready;

    // All byte lanes valid on endpoint traffic
    always_comb begin
        tx_buf.push_word = '0;
        tx_buf.push_word[DATA_LSB +: DATA_W]  = win_data;
        tx_buf.push_word[BV_LSB +: BE_W-CH_W] = BV_ALL;
        tx_buf.push_word[CH_LSB +: CH_W]      = win_ch;
    end

    // Accepted word count
    always_ff @(posedge ft_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tx_count <= '0;
        end else if (tx_buf.push) begin
            tx_count <= tx_count + CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// File: src/ft601_bridge.sv
`default_nettype none

module ft601_bridge (
    input  logic                             ft_clk,
    input  logic                             sys_rst_n,
    // FT601 side, pad split for the board wrapper
    input  logic                             ft_rxf_n,
    input  logic                             ft_txe_n,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ft_data_in,
    input  logic [ft_bridge_pkg::BE_W-1:0]   ft_be_in,
    output logic                             ft_rd_n,
    output logic                             ft_wr_n,
    output logic                             ft_oe_n,
    output logic [ft_bridge_pkg::DATA_W-1:0] ft_data_out,
    output logic [ft_bridge_pkg::BE_W-1:0]   ft_be_out,
    output logic                             ft_data_oe,
    // OUT endpoints
    input  logic                             ep0_rx_ready,
    input  logic                             ep1_rx_ready,
    output logic [ft_bridge_pkg::DATA_W-1:0] ep0_rx_data,
    output logic                             ep0_rx_valid,
    output logic [ft_bridge_pkg::DATA_W-1:0] ep1_rx_data,
    output logic                             ep1_rx_valid,
    // IN endpoints
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep0_tx_data,
    input  logic                             ep0_tx_valid,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep2_tx_data,
    input  logic                             ep2_tx_valid,
    input  logic [ft_bridge_pkg::DATA_W-1:0] ep3_tx_data,
    input  logic                             ep3_tx_valid,
    output logic                             ep0_tx_ready,
    output logic                             ep2_tx_ready,
    output logic                             ep3_tx_ready,
    // Statistics
    output logic [ft_bridge_pkg::CNT_W-1:0]  rx_count,
    output logic [ft_bridge_pkg::CNT_W-1:0]  tx_count
);

    // ==============================
    // Buffers, host to device and back
    // ==============================
    fifo_if rx_buf ();
    fifo_if tx_buf ();

    word_fifo u_rx_fifo (.ft_clk(ft_clk), .sys_rst_n(sys_rst_n), .fifo(rx_buf));
    word_fifo u_tx_fifo (.ft_clk(ft_clk), .sys_rst_n(sys_rst_n), .fifo(tx_buf));

    // Chip-facing sequencer
    ft_bus_fsm u_bus_fsm (
        .ft_clk    (ft_clk),    .sys_rst_n (sys_rst_n),
        .rxf_n     (ft_rxf_n),  .txe_n     (ft_txe_n),
        .data_in   (ft_data_in), .be_in    (ft_be_in),
        .rd_n      (ft_rd_n),   .wr_n      (ft_wr_n),
        .oe_n      (ft_oe_n),   .data_out  (ft_data_out),
        .be_out    (ft_be_out), .data_oe   (ft_data_oe),
        .rx_buf    (rx_buf),    .tx_buf    (tx_buf)
    );

    // Received words out to EP0 and EP1
    rx_endpoint_demux u_rx_demux (
        .ft_clk       (ft_clk),       .sys_rst_n    (sys_rst_n),
        .ep0_rx_ready (ep0_rx_ready), .ep1_rx_ready (ep1_rx_ready),
        .ep0_rx_data  (ep0_rx_data),  .ep0_rx_valid (ep0_rx_valid),
        .ep1_rx_data  (ep1_rx_data),  .ep1_rx_valid (ep1_rx_valid),
        .rx_count     (rx_count),     .rx_buf       (rx_buf)
    );

    // IN endpoints merged into the transmit buffer
    tx_endpoint_arbiter u_tx_arb (
        .ft_clk       (ft_clk),       .sys_rst_n    (sys_rst_n),
        .ep0_tx_data  (ep0_tx_data),  .ep0_tx_valid (ep0_tx_valid),
        .ep2_tx_data  (ep2_tx_data),  .ep2_tx_valid (ep2_tx_valid),
        .ep3_tx_data  (ep3_tx_data),  .ep3_tx_valid (ep3_tx_valid),
        .ep0_tx_ready (ep0_tx_ready), .ep2_tx_ready (ep2_tx_ready),
        .ep3_tx_ready (ep3_tx_ready), .tx_count     (tx_count),
        .tx_buf       (tx_buf)
    );

endmodule

`default_nettype wire

// File: test/tb_ft601_bridge.sv
`default_nettype none

module tb_ft601_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // Traffic sizes and run limit
    // ==============================
    localparam int HOST_WORDS = 300;
    localparam int TX_WORDS   = 100;
    // Traffic needs about 2000 cycles with stalls, ten times that is the ceiling
    localparam int MAX_CYCLES = 20000;

    logic        ft_clk;
    logic        sys_rst_n;
    // Chip side
    logic        ft_rxf_n, ft_txe_n, ft_rd_n, ft_wr_n, ft_oe_n, ft_data_oe;
    logic [31:0] ft_data_in, ft_data_out;
    logic [3:0]  ft_be_in, ft_be_out;
    // Endpoint side
    logic        ep0_rx_ready, ep1_rx_ready, ep0_rx_valid, ep1_rx_valid;
    logic [31:0] ep0_rx_data, ep1_rx_data;
    logic        ep0_tx_ready, ep2_tx_ready, ep3_tx_ready;
    logic [31:0] rx_count, tx_count;

    // Host stream and IN endpoint payloads
    logic [31:0] host_data [HOST_WORDS];
    logic [1:0]  host_ch   [HOST_WORDS];
    logic [31:0] tx_words  [3][TX_WORDS];

    // Scoreboard state
    int          host_idx  = 0;
    int          rx_pos [2] = '{0, 0};
    int          tx_idx [3] = '{0, 0, 0};
    int          offered [3];
    logic        src_valid [3];
    logic [31:0] exp_rx_word [2];
    logic [35:0] exp_tx_word;
    logic [35:0] exp_tx_q [$];
    logic [31:0] rx_hs_cnt = '0;
    logic [31:0] tx_hs_cnt = '0;
    int          cycle_cnt = 0;

    // Sources 0, 1, 2 are EP0, EP2, EP3
    wire         ep0_tx_valid = src_valid[0];
    wire         ep2_tx_valid = src_valid[1];
    wire         ep3_tx_valid = src_valid[2];
    wire  [31:0] ep0_tx_data  = tx_words[0][offered[0]];
    wire  [31:0] ep2_tx_data  = tx_words[1][offered[1]];
    wire  [31:0] ep3_tx_data  = tx_words[2][offered[2]];

    ft601_bridge dut0 (
        .ft_clk       (ft_clk),       .sys_rst_n    (sys_rst_n),
        .ft_rxf_n     (ft_rxf_n),     .ft_txe_n     (ft_txe_n),
        .ft_data_in   (ft_data_in),   .ft_be_in     (ft_be_in),
        .ft_rd_n      (ft_rd_n),      .ft_wr_n      (ft_wr_n),
        .ft_oe_n      (ft_oe_n),      .ft_data_out  (ft_data_out),
        .ft_be_out    (ft_be_out),    .ft_data_oe   (ft_data_oe),
        .ep0_rx_ready (ep0_rx_ready), .ep1_rx_ready (ep1_rx_ready),
        .ep0_rx_data  (ep0_rx_data),  .ep0_rx_valid (ep0_rx_valid),
        .ep1_rx_data  (ep1_rx_data),  .ep1_rx_valid (ep1_rx_valid),
        .ep0_tx_data  (ep0_tx_data),  .ep0_tx_valid (ep0_tx_valid),
        .ep2_tx_data  (ep2_tx_data),  .ep2_tx_valid (ep2_tx_valid),
        .ep3_tx_data  (ep3_tx_data),  .ep3_tx_valid (ep3_tx_valid),
        .ep0_tx_ready (ep0_tx_ready), .ep2_tx_ready (ep2_tx_ready),
        .ep3_tx_ready (ep3_tx_ready),
        .rx_count     (rx_count),     .tx_count     (tx_count)
    );

    initial begin
        ft_clk = 1'b0;
        forever #5 ft_clk = ~ft_clk;
    end

    always @(posedge ft_clk) cycle_cnt <= cycle_cnt + 1;

    // ==============================
    // Helpers
    // ==============================
    task automatic fail_run(string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Channel code carried by each IN source
    function automatic logic [1:0] source_channel(int i);
        return (i == 0) ? 2'd0 : (i == 1) ? 2'd2 : 2'd3;
    endfunction

    function automatic logic source_ready(int i);
        return (i == 0) ? ep0_tx_ready : (i == 1) ? ep2_tx_ready : ep3_tx_ready;
    endfunction

    // First host word at or after from on channel ch
    function automatic int next_on_channel(int from, logic [1:0] ch);
        int idx;
        idx = from;
        while (idx < HOST_WORDS && host_ch[idx] != ch) begin
            idx++;
        end
        return idx;
    endfunction

    function automatic bit traffic_drained();
        return host_idx == HOST_WORDS && exp_tx_q.size() == 0 &&
               next_on_channel(rx_pos[0], 2'd0) == HOST_WORDS &&
               next_on_channel(rx_pos[1], 2'd1) == HOST_WORDS &&
               tx_idx[0] == TX_WORDS && tx_idx[1] == TX_WORDS && tx_idx[2] == TX_WORDS;
    endfunction

    // Word the OUT endpoint must see, only one the host already sent
    task automatic expect_delivery(int ep);
        int idx;
        idx = next_on_channel(rx_pos[ep], 2'(ep));
        if (idx >= host_idx) begin
            fail_run($sformatf("EP%0d handshake with no matching word sent by the host", ep));
        end else begin
            exp_rx_word[ep] = host_data[idx];
            rx_pos[ep] = idx + 1;
        end
    endtask

    task automatic drive_inputs();
        logic slow;
        // Every other 256 cycles the OUT endpoints mostly stall
        slow = (cycle_cnt % 512) >= 256;
        if (host_idx < HOST_WORDS) begin
            ft_rxf_n   = ($urandom_range(0, 3) == 0);
            ft_data_in = host_data[host_idx];
            ft_be_in   = {host_ch[host_idx], 2'($urandom_range(0, 3))};
        end else begin
            ft_rxf_n = 1'b1;
        end
        ft_txe_n     = ($urandom_range(0, 3) == 0);
        ep0_rx_ready = slow ? ($urandom_range(0, 7) == 0) : ($urandom_range(0, 3) != 0);
        ep1_rx_ready = slow ? ($urandom_range(0, 7) == 0) : ($urandom_range(0, 3) != 0);
        // A valid word stays up until its handshake
        for (int i = 0; i < 3; i++) begin
            if (!(src_valid[i] && offered[i] == tx_idx[i])) begin
                src_valid[i] = (tx_idx[i] < TX_WORDS) && ($urandom_range(0, 1) == 1);
                offered[i]   = (tx_idx[i] < TX_WORDS) ? tx_idx[i] : 0;
            end
        end
    endtask

    // ==============================
    // Monitor, mid-cycle view of the coming edge
    // ==============================
    always @(negedge ft_clk) begin
        if (sys_rst_n) begin
            // Host hands over its head word
            if (!ft_rd_n && !ft_oe_n && !ft_rxf_n) begin
                host_idx <= host_idx + 1;
            end
            if (ep0_rx_valid && ep0_rx_ready) begin
                expect_delivery(0);
            end
            if (ep1_rx_valid && ep1_rx_ready) begin
                expect_delivery(1);
            end
            if ((ep0_rx_valid && ep0_rx_ready) || (ep1_rx_valid && ep1_rx_ready)) begin
                rx_hs_cnt <= rx_hs_cnt + 32'd1;
            end
            // Bus write takes the oldest accepted word, before this edge's push
            if (!ft_wr_n && !ft_txe_n) begin
                if (exp_tx_q.size() == 0) begin
                    fail_run("Bus write with no accepted word pending");
                end else begin
                    exp_tx_word = exp_tx_q.pop_front();
                end
            end
            for (int i = 0; i < 3; i++) begin
                if (src_valid[i] && source_ready(i)) begin
                    exp_tx_q.push_back({source_channel(i), 2'b11, tx_words[i][offered[i]]});
                    tx_idx[i] = tx_idx[i] + 1;
                    tx_hs_cnt <= tx_hs_cnt + 32'd1;
                end
            end
        end
    end

    // ==============================
    // Assertions
    // ==============================
    a_reset_idle: assert property (@(posedge ft_clk) (!sys_rst_n && cycle_cnt >= 2) |->
        (ft_rd_n && ft_wr_n && ft_oe_n && !ft_data_oe && !ep0_rx_valid && !ep1_rx_valid &&
         rx_count == '0 && tx_count == '0))
        else fail_run("Outputs not idle during reset");

    a_ep0_data: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        (ep0_rx_valid && ep0_rx_ready) |-> ep0_rx_data == exp_rx_word[0])
        else fail_run($sformatf("ERR %0t ep0_rx_data exp %h got %h",
                                $time, exp_rx_word[0], $sampled(ep0_rx_data)));

    a_ep1_data: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        (ep1_rx_valid && ep1_rx_ready) |-> ep1_rx_data == exp_rx_word[1])
        else fail_run($sformatf("ERR %0t ep1_rx_data exp %h got %h",
                                $time, exp_rx_word[1], $sampled(ep1_rx_data)));

    a_one_ready: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        $onehot0({ep0_tx_ready, ep2_tx_ready, ep3_tx_ready}))
        else fail_run("More than one transmit ready high");

    a_priority: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        !(ep0_tx_valid && (ep2_tx_ready || ep3_tx_ready)) && !(ep2_tx_valid && ep3_tx_ready))
        else fail_run("Ready given to a lower priority source");

    a_tx_word: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        (!ft_wr_n && !ft_txe_n) |-> {ft_be_out, ft_data_out} == exp_tx_word)
        else fail_run($sformatf("ERR %0t ft_be_out/ft_data_out exp %h got %h",
                                $time, exp_tx_word, $sampled({ft_be_out, ft_data_out})));

    a_tx_oe: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        (!ft_wr_n && !ft_txe_n) |-> ft_data_oe)
        else fail_run("Bus write while the data bus is not driven");

    a_strobes: assert property (@(posedge ft_clk) disable iff (!sys_rst_n)
        !(!ft_rd_n && !ft_wr_n) && !(!ft_oe_n && ft_data_oe) && (!ft_rd_n -> !ft_oe_n))
        else fail_run("Bus strobe conflict between rd_n, wr_n, oe_n and data_oe");

    // Counters settle on the edge, compare half a cycle later
    a_rx_count: assert property (@(negedge ft_clk) disable iff (!sys_rst_n)
        rx_count == rx_hs_cnt)
        else fail_run($sformatf("ERR %0t rx_count exp %0d got %0d",
                                $time, rx_hs_cnt, $sampled(rx_count)));

    a_tx_count: assert property (@(negedge ft_clk) disable iff (!sys_rst_n)
        tx_count == tx_hs_cnt)
        else fail_run($sformatf("ERR %0t tx_count exp %0d got %0d",
                                $time, tx_hs_cnt, $sampled(tx_count)));

    // ==============================
    // Stimulus and end of run
    // ==============================
    initial begin
        void'($urandom(32'hbed2_a35c));
        sys_rst_n    = 1'b0;
        ft_rxf_n     = 1'b1;
        ft_txe_n     = 1'b1;
        ft_data_in   = '0;
        ft_be_in     = '0;
        ep0_rx_ready = 1'b0;
        ep1_rx_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            src_valid[i] = 1'b0;
            offered[i]   = 0;
        end
        for (int i = 0; i < HOST_WORDS; i++) begin
            host_data[i] = $urandom;
            host_ch[i]   = 2'($urandom_range(0, 3));
        end
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < TX_WORDS; i++) begin
                tx_words[s][i] = $urandom;
            end
        end
        repeat (10) @(posedge ft_clk);
        #1;
        sys_rst_n = 1'b1;
        while (!traffic_drained() && cycle_cnt < MAX_CYCLES) begin
            @(posedge ft_clk);
            #1;
            drive_inputs();
        end
        if (traffic_drained()) begin
            // Let the last edge's checks run
            repeat (4) @(posedge ft_clk);
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_run($sformatf("Timeout after %0d cycles with traffic still pending",
                               cycle_cnt));
        end
    end

endmodule

`default_nettype wire

// File: build.f
src/ft_bridge_pkg.sv
src/fifo_if.sv
src/word_fifo.sv
src/ft_bus_fsm.sv
src/rx_endpoint_demux.sv
src/tx_endpoint_arbiter.sv
src/ft601_bridge.sv
test/tb_ft601_bridge.sv

// File: Makefile
TOP := tb_ft601_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f build.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir
